// ==== test/f2_sys_golden.txt ====
# D address ds_n cs sel   (cs packs rom_n down to sound_n, sel is ss_data_sel)
# H index word = handler ROM, S ssp_hi ssp_lo = save pointer, R pointer = restore pointer
D 000000 0 3f 0
D 000004 1 3f 0
D 00007c 2 7f 1
D 00007e 0 7f 1
D 040000 0 3f 0
D 100000 0 5f 0
D 800100 2 6f 0
D 900000 0 7d 0
D 200000 0 77 0
D 300000 1 7b 0
D 320000 0 7e 0
D 310000 0 7f 0
D ff0010 0 7f 1
D ff0100 0 7f 0
D 100000 3 7f 0
D 400000 0 7f 0
H 0 48e7
H 1 fffe
H 2 4e6e
H 3 2f0e
H 4 4df9
H 5 00ff
H 6 0000
H 7 2c8f
H 8 2c5f
H 9 4e66
H a 4cdf
H b 7fff
H c 4e73
S 00fe 7ff0
R 00fd6a40

// ==== compile.f ====
+incdir+hdl
hdl/f2_sys_pkg.sv
hdl/ss_settle_timer.sv
hdl/ss_sequencer.sv
hdl/cpu_addr_decode.sv
hdl/ss_bus_rom.sv
hdl/irq_ctrl.sv
hdl/f2_sys_ctrl.sv
test/f2_sys_ctrl_sva.sv
test/tb_f2_sys_ctrl.sv

// ==== test/tb_f2_sys_ctrl.sv ====
`timescale 1ns/100ps
`default_nettype none

`include "f2_sys_defines.svh"

module tb_f2_sys_ctrl;

    import f2_sys_pkg::*;

    localparam irq_src_t src_idle = '{vblank_n: 1'b1, dma_n: 1'b1, save: 1'b0};

    logic                  clk;
    logic                  reset;
    cpu_bus_t              cpu;
    irq_src_t              irq_src;
    logic                  ss_do_save;
    logic                  ss_do_restore;
    logic                  ss_ack;
    logic [`F2_SSP_W-1:0]  restore_ssp;
    chip_sel_t             cs;
    logic [`F2_DATA_W-1:0] ss_data;
    logic                  ss_data_sel;
    logic [2:0]            ipl_n;
    logic                  cpu_reset;
    logic                  cpu_pause;
    ss_xfer_t              ss_xfer;
    logic [`F2_SSP_W-1:0]  saved_ssp;
    ss_state_t             ss_state_out;

    // Golden data
    logic [23:0] dec_addr [$];
    logic [1:0]  dec_ds [$];
    logic [6:0]  dec_cs [$];
    logic        dec_sel [$];
    logic [15:0] handler_words [`SS_HANDLER_WORDS];
    int          handler_count = 0;
    logic [15:0] save_hi;
    logic [15:0] save_lo;
    logic [31:0] restore_ptr;

    integer seed = 32'h728ee0d9;
    int     errors = 0;
    int     checks = 0;
    int     tests_run = 0;
    int     tests_failed = 0;
    int     test_err_base;
    string  test_name;

    f2_sys_ctrl i_dut (
        .clk           (clk),
        .reset         (reset),
        .cpu           (cpu),
        .irq_src       (irq_src),
        .ss_do_save    (ss_do_save),
        .ss_do_restore (ss_do_restore),
        .ss_ack        (ss_ack),
        .restore_ssp   (restore_ssp),
        .cs            (cs),
        .ss_data       (ss_data),
        .ss_data_sel   (ss_data_sel),
        .ipl_n         (ipl_n),
        .cpu_reset     (cpu_reset),
        .cpu_pause     (cpu_pause),
        .ss_xfer       (ss_xfer),
        .saved_ssp     (saved_ssp),
        .ss_state_out  (ss_state_out)
    );

    bind f2_sys_ctrl f2_sys_ctrl_sva i_sva (
        .clk          (clk),
        .reset        (reset),
        .ss_xfer      (ss_xfer),
        .ss_ack       (ss_ack),
        .ipl_n        (ipl_n),
        .cpu_pause    (cpu_pause),
        .cpu_reset    (cpu_reset)
    );

    always #4 clk = ~clk;

    ////////////////////////////////////////////////////////////
    // Helpers

    task automatic abort_run(input string msg);
        $display("%s", msg);
        $display("TESTBENCH FAILED");
        $finish;
    endtask

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        checks++;
        assert (got === exp) else begin
            errors++;
            $display("CHECK FAILED %s: got %h expected %h", name, got, exp);
        end
    endtask

    task automatic start_test(input string name);
        test_name = name;
        test_err_base = errors;
        tests_run++;
    endtask

    task automatic finish_test();
        if (errors == test_err_base) begin
            $display("test %0d %s: ok", tests_run, test_name);
        end else begin
            tests_failed++;
            $display("test %0d %s: %0d errors", tests_run, test_name, errors - test_err_base);
        end
    endtask

    task automatic load_golden();
        int          fd;
        string       line;
        string       tag;
        logic [31:0] f1;
        logic [31:0] f2;
        logic [31:0] f3;
        logic [31:0] f4;
        fd = $fopen("test/f2_sys_golden.txt", "r");
        if (fd == 0) begin
            abort_run("Could not open the golden data file");
        end else begin
            while ($fgets(line, fd)) begin
                if (line.len() < 2 || line.substr(0, 0) == "#") begin
                    continue;
                end
                void'($sscanf(line, "%s %h %h %h %h", tag, f1, f2, f3, f4));
                if (tag == "D") begin
                    dec_addr.push_back(f1[23:0]);
                    dec_ds.push_back(f2[1:0]);
                    dec_cs.push_back(f3[6:0]);
                    dec_sel.push_back(f4[0]);
                end else if (tag == "H") begin
                    handler_words[f1] = f2[15:0];
                    handler_count++;
                end else if (tag == "S") begin
                    save_hi = f1[15:0];
                    save_lo = f2[15:0];
                end else if (tag == "R") begin
                    restore_ptr = f1;
                end
            end
            $fclose(fd);
            if (dec_addr.size() == 0 || handler_count != `SS_HANDLER_WORDS) begin
                errors++;
                $display("Golden data file is missing decode vectors or handler words");
            end
        end
    endtask

    task automatic drive_bus(input logic [23:0] a, input logic [1:0] ds,
                             input logic rw, input logic [15:0] d, input logic [2:0] fc);
        cpu.addr  = a;
        cpu.ds_n  = ds;
        cpu.rw    = rw;
        cpu.wdata = d;
        cpu.fc    = fc;
    endtask

    task automatic write_word(input logic [23:0] a, input logic [15:0] d);
        @(posedge clk);
        #1 drive_bus(a, 2'b00, 1'b0, d, 3'b101);
        @(posedge clk);
        #1 drive_bus(24'h0, 2'b11, 1'b1, 16'h0, 3'b101);
    endtask

    // Outputs are combinational, sampled mid cycle
    task automatic read_word(input logic [23:0] a, input logic [1:0] ds,
                             output logic [15:0] d, output logic sel, output chip_sel_t cs_got);
        @(posedge clk);
        #1 drive_bus(a, ds, 1'b1, 16'h0, 3'b101);
        @(negedge clk);
        d      = ss_data;
        sel    = ss_data_sel;
        cs_got = cs;
    endtask

    // Reset vector words at 0x000000 to 0x000006
    task automatic check_vector_reads();
        logic [15:0] rd;
        logic        sel;
        chip_sel_t   cs_got;
        logic [15:0] vec_exp [4];
        vec_exp[0] = restore_ptr[31:16];
        vec_exp[1] = restore_ptr[15:0];
        vec_exp[2] = `SS_RESUME_HI;
        vec_exp[3] = `SS_RESUME_LO;
        for (int w = 0; w < 4; w++) begin
            read_word(24'(2 * w), 2'b00, rd, sel, cs_got);
            check_value("ss_data_sel", sel, 1'b1);
            check_value("ss_data", rd, vec_exp[w]);
        end
    endtask

    task automatic pulse_irq(input irq_src_t active);
        @(posedge clk);
        #1 irq_src = active;
        @(posedge clk);
        #1 irq_src = src_idle;
    endtask

    task automatic ack_level(input logic [2:0] level);
        @(posedge clk);
        #1 drive_bus(24'hfffff0 | {20'h0, level, 1'b0}, 2'b10, 1'b1, 16'h0, 3'b111);
        @(posedge clk);
        #1 drive_bus(24'h0, 2'b11, 1'b1, 16'h0, 3'b101);
    endtask

    task automatic wait_ipl(input logic [2:0] exp);
        int n;
        n = 0;
        while (ipl_n !== exp && n < 8) begin
            @(negedge clk);
            n++;
        end
        check_value("ipl_n", ipl_n, exp);
    endtask

    task automatic wait_state(input ss_state_t st, input int limit, input string what);
        int n;
        n = 0;
        while (ss_state_out != st) begin
            @(negedge clk);
            n++;
            if (n > limit) begin
                abort_run({"Timed out waiting for ", what});
            end
        end
    endtask

    // Save engine model, ack after a random delay
    task automatic serve_engine(input logic exp_write, input logic [31:0] ptr);
        int n;
        int delay;
        n = 0;
        while (!ss_xfer.req) begin
            @(negedge clk);
            n++;
            if (n > 200) begin
                abort_run("Timed out waiting for a save engine request");
            end
        end
        check_value("ss_xfer.write", ss_xfer.write, exp_write);
        delay = ($random(seed) & 15) + 1;
        repeat (delay) @(posedge clk);
        #1;
        ss_ack      = 1'b1;
        restore_ssp = ptr;
        n = 0;
        while (ss_xfer.req) begin
            @(negedge clk);
            n++;
            if (n > 20) begin
                abort_run("Timed out waiting for req to fall after ack");
            end
        end
        @(posedge clk);
        #1 ss_ack = 1'b0;
    endtask

    ////////////////////////////////////////////////////////////
    // Test sequence

    initial begin : main
        logic [15:0] rd;
        logic        sel;
        chip_sel_t   cs_got;
        chip_sel_t   cs_rom;
        int          n;

        clk           = 1'b0;
        reset         = 1'b1;
        irq_src       = src_idle;
        ss_do_save    = 1'b0;
        ss_do_restore = 1'b0;
        ss_ack        = 1'b0;
        restore_ssp   = '0;
        drive_bus(24'h0, 2'b11, 1'b1, 16'h0, 3'b101);
        load_golden();
        repeat (10) @(posedge clk);
        #1 reset = 1'b0;

        start_test("address decode");
        foreach (dec_addr[i]) begin
            read_word(dec_addr[i], dec_ds[i], rd, sel, cs_got);
            check_value("cs", cs_got, dec_cs[i]);
            check_value("ss_data_sel", sel, dec_sel[i]);
        end
        finish_test();

        start_test("interrupts");
        pulse_irq('{vblank_n: 1'b0, dma_n: 1'b1, save: 1'b0});
        wait_ipl(~3'd5);
        pulse_irq('{vblank_n: 1'b1, dma_n: 1'b0, save: 1'b0});   // Rising dma_n on release
        wait_ipl(~3'd6);
        pulse_irq('{vblank_n: 1'b1, dma_n: 1'b1, save: 1'b1});
        wait_ipl(~3'd7);
        ack_level(3'd7);
        wait_ipl(~3'd6);
        ack_level(3'd6);
        wait_ipl(~3'd5);
        ack_level(3'd5);
        wait_ipl(3'b111);
        finish_test();

        start_test("handler reads");
        for (int i = 0; i < `SS_HANDLER_WORDS; i++) begin
            read_word(24'hff0000 + 24'(2 * i), 2'b00, rd, sel, cs_got);
            check_value("ss_data_sel", sel, 1'b1);
            check_value("ss_data", rd, handler_words[i]);
        end
        drive_bus(24'h0, 2'b11, 1'b1, 16'h0, 3'b101);
        finish_test();

        start_test("save");
        @(posedge clk);
        #1 ss_do_save = 1'b1;
        @(posedge clk);
        #1 ss_do_save = 1'b0;
        write_word(`SS_SSP_HI_ADDR, save_hi);
        write_word(`SS_SSP_LO_ADDR, save_lo);
        check_value("saved_ssp", saved_ssp, {save_hi, save_lo});
        n = 0;
        while (!cpu_pause && n < 4) begin
            @(negedge clk);
            n++;
        end
        check_value("cpu_pause", cpu_pause, 1'b1);
        serve_engine(1'b1, 32'h0);
        wait_state(sst_idle, 16, "the save to finish");
        check_value("cpu_pause", cpu_pause, 1'b0);
        finish_test();

        start_test("restore");
        @(posedge clk);
        #1 ss_do_restore = 1'b1;
        @(posedge clk);
        #1 ss_do_restore = 1'b0;
        @(negedge clk);
        check_value("cpu_reset", cpu_reset, 1'b1);
        serve_engine(1'b0, restore_ptr);
        wait_state(sst_hold_reset, 8, "the reset hold");
        check_value("cpu_reset", cpu_reset, 1'b1);
        check_vector_reads();
        check_value("cpu_reset", cpu_reset, 1'b1);   // Reads fell inside the hold
        n = 0;
        while (cpu_reset) begin
            @(negedge clk);
            n++;
            if (n > `SS_HOLD_CYCLES + 50) begin
                abort_run("Timed out waiting for the CPU reset to be released");
            end
        end
        check_vector_reads();   // Vector stays until the restart write
        write_word(`SS_SSP_LO_ADDR, restore_ptr[15:0]);
        wait_state(sst_idle, 8, "the restart write");
        cs_rom = '1;
        cs_rom.rom_n = 1'b0;
        read_word(24'h000000, 2'b00, rd, sel, cs_got);
        check_value("cs", cs_got, cs_rom);
        check_value("ss_data_sel", sel, 1'b0);
        drive_bus(24'h0, 2'b11, 1'b1, 16'h0, 3'b101);
        finish_test();

        repeat (4) @(posedge clk);
        $display("%0d tests, %0d failed, %0d checks, %0d check errors, %0d assertion errors",
                 tests_run, tests_failed, checks, errors, i_dut.i_sva.error_count);
        if (errors == 0 && i_dut.i_sva.error_count == 0) begin
            $display("TESTBENCH PASSED");
        end else begin
            $display("TESTBENCH FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== test/f2_sys_ctrl_sva.sv ====
`timescale 1ns/100ps
`default_nettype none

module f2_sys_ctrl_sva (
    input wire                        clk,
    input wire                        reset,
    input wire f2_sys_pkg::ss_xfer_t  ss_xfer,
    input wire                        ss_ack,
    input wire [2:0]                  ipl_n,
    input wire                        cpu_pause,
    input wire                        cpu_reset
);

    int error_count = 0;

    ////////////////////////////////////////////////////////////
    // Save engine handshake

    req_held: assert property (@(posedge clk) disable iff (reset)
        ss_xfer.req && !ss_ack |=> ss_xfer.req)
        else begin
            error_count++;
            $error("req dropped before ack rose");
        end

    write_stable: assert property (@(posedge clk) disable iff (reset)
        ss_xfer.req |=> !ss_xfer.req || $stable(ss_xfer.write))
        else begin
            error_count++;
            $error("write changed while req was high");
        end

    ////////////////////////////////////////////////////////////
    // CPU side outputs

    ipl_in_reset: assert property (@(posedge clk) reset |=> ipl_n == 3'b111)
        else begin
            error_count++;
            $error("ipl_n not idle during reset");
        end

    // Restore transfer pauses without reset, settle and hold reset without pause
    pause_vs_reset: assert property (@(posedge clk) disable iff (reset)
        !(cpu_pause && cpu_reset))
        else begin
            error_count++;
            $error("cpu_pause and cpu_reset high together");
        end

endmodule

`default_nettype wire

// ==== hdl/f2_sys_ctrl.sv ====
`timescale 1ns/100ps
`default_nettype none

`include "f2_sys_defines.svh"

module f2_sys_ctrl (
    input  wire                       clk,
    input  wire                       reset,
    input  wire f2_sys_pkg::cpu_bus_t cpu,
    input  wire f2_sys_pkg::irq_src_t irq_src,
    input  wire                       ss_do_save,
    input  wire                       ss_do_restore,
    input  wire                       ss_ack,
    input  wire [`F2_SSP_W-1:0]       restore_ssp,
    output f2_sys_pkg::chip_sel_t     cs,
    output logic [`F2_DATA_W-1:0]     ss_data,
    output logic                      ss_data_sel,
    output logic [2:0]                ipl_n,
    output logic                      cpu_reset,
    output logic                      cpu_pause,
    output f2_sys_pkg::ss_xfer_t      ss_xfer,
    output logic [`F2_SSP_W-1:0]      saved_ssp,
    output f2_sys_pkg::ss_state_t     ss_state_out
);

    import f2_sys_pkg::*;

    region_t              region;
    logic                 restart;
    logic                 vector_load;
    logic [`F2_SSP_W-1:0] vector_ssp;
    logic                 timer_start;
    logic                 timer_long;
    logic                 timer_done;

    ////////////////////////////////////////////////////////////
    // CPU bus side

    cpu_addr_decode i_decode (
        .cpu     (cpu),
        .restart (restart),
        .cs      (cs),
        .region  (region)
    );

    ss_bus_rom i_bus_rom (
        .clk         (clk),
        .reset       (reset),
        .cpu         (cpu),
        .region      (region),
        .vector_load (vector_load),
        .vector_ssp  (vector_ssp),
        .ss_data     (ss_data),
        .ss_data_sel (ss_data_sel)
    );

    irq_ctrl i_irq (
        .clk     (clk),
        .reset   (reset),
        .cpu     (cpu),
        .irq_src (irq_src),
        .ipl_n   (ipl_n)
    );

    ////////////////////////////////////////////////////////////
    // Save-state control

    ss_sequencer i_seq (
        .clk           (clk),
        .reset         (reset),
        .cpu           (cpu),
        .ss_do_save    (ss_do_save),
        .ss_do_restore (ss_do_restore),
        .ss_ack        (ss_ack),
        .restore_ssp   (restore_ssp),
        .timer_done    (timer_done),
        .timer_start   (timer_start),
        .timer_long    (timer_long),
        .ss_xfer       (ss_xfer),
        .saved_ssp     (saved_ssp),
        .vector_load   (vector_load),
        .vector_ssp    (vector_ssp),
        .restart       (restart),
        .cpu_reset     (cpu_reset),
        .cpu_pause     (cpu_pause),
        .ss_state_out  (ss_state_out)
    );

    ss_settle_timer i_timer (
        .clk       (clk),
        .reset     (reset),
        .start     (timer_start),
        .long_hold (timer_long),
        .done      (timer_done)
    );

endmodule

`default_nettype wire

// ==== hdl/irq_ctrl.sv ====
`timescale 1ns/100ps
`default_nettype none

module irq_ctrl (
    input  wire                       clk,
    input  wire                       reset,
    input  wire f2_sys_pkg::cpu_bus_t cpu,
    input  wire f2_sys_pkg::irq_src_t irq_src,
    output logic [2:0]                ipl_n
);

    import f2_sys_pkg::*;

    localparam irq_src_t src_idle = '{vblank_n: 1'b1, dma_n: 1'b1, save: 1'b0};

    irq_src_t src_q;
    irq_src_t src_prev;
    logic     req5;
    logic     req6;
    logic     req7;
    logic     iack;
    logic     vbl_fall;
    logic     dma_rise;
    logic     save_rise;

    // Interrupt acknowledge cycle on the lower strobe
    assign iack = (&cpu.fc) && !cpu.ds_n[0];

    assign vbl_fall  = src_prev.vblank_n && !src_q.vblank_n;
    assign dma_rise  = !src_prev.dma_n && src_q.dma_n;
    assign save_rise = !src_prev.save && src_q.save;

    always_ff @(posedge clk) begin
        if (reset) begin
            src_q    <= src_idle;
            src_prev <= src_idle;
            req5     <= 1'b0;
            req6     <= 1'b0;
            req7     <= 1'b0;
        end else begin
            src_q    <= irq_src;
            src_prev <= src_q;

            if (vbl_fall) begin
                req5 <= 1'b1;
            end
            if (dma_rise) begin
                req6 <= 1'b1;
            end
            if (save_rise) begin
                req7 <= 1'b1;
            end

            // Clear wins over a new edge in the same clock
            if (iack && cpu.addr[3:1] == 3'd5) begin
                req5 <= 1'b0;
            end
            if (iack && cpu.addr[3:1] == 3'd6) begin
                req6 <= 1'b0;
            end
            if (iack && cpu.addr[3:1] == 3'd7) begin
                req7 <= 1'b0;
            end
        end
    end

    always_comb begin
        if (req7) begin
            ipl_n = ~3'd7;
        end else if (req6) begin
            ipl_n = ~3'd6;
        end else if (req5) begin
            ipl_n = ~3'd5;
        end else begin
            ipl_n = 3'b111;
        end
    end

endmodule

`default_nettype wire

// ==== hdl/ss_bus_rom.sv ====
`timescale 1ns/100ps
`default_nettype none

`include "f2_sys_defines.svh"

module ss_bus_rom (
    input  wire                       clk,
    input  wire                       reset,
    input  wire f2_sys_pkg::cpu_bus_t cpu,
    input  wire f2_sys_pkg::region_t  region,
    input  wire                       vector_load,
    input  wire [`F2_SSP_W-1:0]       vector_ssp,
    output logic [`F2_DATA_W-1:0]     ss_data,
    output logic                      ss_data_sel
);

    import f2_sys_pkg::*;

    // Save handler, entered through the level 7 autovector
    localparam logic [`F2_DATA_W-1:0] handler_rom [`SS_HANDLER_WORDS] = '{
        16'h48e7, 16'hfffe, 16'h4e6e, 16'h2f0e,
        16'h4df9, 16'h00ff, 16'h0000, 16'h2c8f,   // Restart lands at 0x8
        16'h2c5f, 16'h4e66, 16'h4cdf, 16'h7fff,
        16'h4e73
    };

    logic [`F2_DATA_W-1:0] reset_vec [4];
    logic                  vec_valid;
    logic [3:0]            rom_idx;

    assign rom_idx = cpu.addr[4:1];

    always_ff @(posedge clk) begin
        if (vector_load) begin
            reset_vec[0] <= vector_ssp[`F2_SSP_W-1:`F2_DATA_W];   // SSP
            reset_vec[1] <= vector_ssp[`F2_DATA_W-1:0];
            reset_vec[2] <= `SS_RESUME_HI;                      // PC
            reset_vec[3] <= `SS_RESUME_LO;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            vec_valid <= 1'b0;
        end else if (vector_load) begin
            vec_valid <= 1'b1;
        end
    end

    always_comb begin
        ss_data     = '0;
        ss_data_sel = 1'b0;
        case (region)
            rgn_ss_save: begin
                ss_data_sel = 1'b1;
                if (rom_idx < 4'(`SS_HANDLER_WORDS)) begin
                    ss_data = handler_rom[rom_idx];
                end
            end
            rgn_ss_reset: begin
                ss_data_sel = 1'b1;
                if (vec_valid) begin
                    ss_data = reset_vec[cpu.addr[2:1]];
                end
            end
            rgn_ss_vec: begin
                ss_data_sel = 1'b1;
                ss_data     = cpu.addr[1] ? 16'h0000 : 16'h00ff;
            end
            default: begin
                ss_data_sel = 1'b0;
            end
        endcase
    end

endmodule

`default_nettype wire

// ==== hdl/cpu_addr_decode.sv ====
`timescale 1ns/100ps
`default_nettype none

module cpu_addr_decode (
    input  wire f2_sys_pkg::cpu_bus_t cpu,
    input  wire                     restart,
    output f2_sys_pkg::chip_sel_t   cs,
    output f2_sys_pkg::region_t     region
);

    import f2_sys_pkg::*;

    // Earlier items win, so the small windows come first
    always_comb begin
        region = rgn_none;
        if (cpu.ds_n != 2'b11) begin
            casez (cpu.addr)
                24'h00000?: region = restart ? rgn_ss_reset : rgn_rom;
                24'h00007c,
                24'h00007e: region = rgn_ss_vec;   // Level 7 autovector
                24'h0?????: region = rgn_rom;
                24'h1?????: region = rgn_work;
                24'h8?????: region = rgn_screen;
                24'h9?????: region = rgn_object;
                24'h2?????: region = rgn_color;
                24'h30????: region = rgn_io;
                24'h32????: region = rgn_sound;
                24'hff00??: region = rgn_ss_save;
                default:    region = rgn_none;
            endcase
        end
    end

    always_comb begin
        cs = '1;
        case (region)
            rgn_rom:    cs.rom_n = 1'b0;
            rgn_work:   cs.work_n = 1'b0;
            rgn_screen: cs.screen_n = 1'b0;
            rgn_color:  cs.color_n = 1'b0;
            rgn_io:     cs.io_n = 1'b0;
            rgn_object: cs.object_n = 1'b0;
            rgn_sound:  cs.sound_n = 1'b0;
            default:    cs = '1;   // Save-state regions have no device
        endcase
    end

endmodule

`default_nettype wire

// ==== hdl/ss_sequencer.sv ====
`timescale 1ns/100ps
`default_nettype none

`include "f2_sys_defines.svh"

module ss_sequencer (
    input  wire                     clk,
    input  wire                     reset,
    input  wire f2_sys_pkg::cpu_bus_t cpu,
    input  wire                     ss_do_save,
    input  wire                     ss_do_restore,
    input  wire                     ss_ack,
    input  wire [`F2_SSP_W-1:0]     restore_ssp,
    input  wire                     timer_done,
    output logic                    timer_start,
    output logic                    timer_long,
    output f2_sys_pkg::ss_xfer_t    ss_xfer,
    output logic [`F2_SSP_W-1:0]    saved_ssp,
    output logic                    vector_load,
    output logic [`F2_SSP_W-1:0]    vector_ssp,
    output logic                    restart,
    output logic                    cpu_reset,
    output logic                    cpu_pause,
    output f2_sys_pkg::ss_state_t   ss_state_out
);

    import f2_sys_pkg::*;

    ss_state_t state;
    logic      ssp_hi_wr;
    logic      ssp_lo_wr;
    logic      xfer_done;

    // Full-word writes from the handler
    assign ssp_hi_wr = (cpu.ds_n == 2'b00) && !cpu.rw && (cpu.addr == `SS_SSP_HI_ADDR);
    assign ssp_lo_wr = (cpu.ds_n == 2'b00) && !cpu.rw && (cpu.addr == `SS_SSP_LO_ADDR);

    assign xfer_done = !ss_xfer.req && !ss_ack;   // Last phase of the handshake

    ////////////////////////////////////////////////////////////
    // State machine

    always_ff @(posedge clk) begin
        if (reset) begin
            state       <= sst_idle;
            ss_xfer     <= '0;
            timer_start <= 1'b0;
            timer_long  <= 1'b0;
        end else begin
            timer_start <= 1'b0;
            case (state)
                sst_idle: begin
                    if (ss_do_restore) begin
                        state       <= sst_restore_settle;
                        timer_start <= 1'b1;
                        timer_long  <= 1'b0;
                    end else if (ss_do_save) begin
                        state <= sst_start_save;
                    end
                end

                sst_start_save: begin
                    if (ssp_hi_wr) begin
                        saved_ssp[31:16] <= cpu.wdata;
                        state            <= sst_wait_save;
                    end
                end

                sst_wait_save: begin
                    if (ssp_lo_wr) begin
                        saved_ssp[15:0] <= cpu.wdata;
                        state           <= sst_save_settle;
                        timer_start     <= 1'b1;
                        timer_long      <= 1'b0;
                    end
                end

                sst_save_settle: begin
                    if (timer_done) begin
                        ss_xfer <= '{req: 1'b1, write: 1'b1};
                        state   <= sst_save_xfer;
                    end
                end

                sst_save_xfer: begin
                    if (ss_xfer.req && ss_ack) begin
                        ss_xfer.req <= 1'b0;
                    end else if (xfer_done) begin
                        ss_xfer.write <= 1'b0;
                        state         <= sst_idle;
                    end
                end

                sst_restore_settle: begin
                    if (timer_done) begin
                        ss_xfer <= '{req: 1'b1, write: 1'b0};
                        state   <= sst_restore_xfer;
                    end
                end

                sst_restore_xfer: begin
                    if (ss_xfer.req && ss_ack) begin
                        ss_xfer.req <= 1'b0;
                        vector_ssp  <= restore_ssp;   // Valid with ack
                    end else if (xfer_done) begin
                        state       <= sst_hold_reset;
                        timer_start <= 1'b1;
                        timer_long  <= 1'b1;
                    end
                end

                sst_hold_reset: begin
                    if (timer_done) begin
                        state <= sst_wait_reset;
                    end
                end

                sst_wait_reset: begin
                    if (ssp_lo_wr) begin
                        state <= sst_idle;   // Restart handler is running
                    end
                end

                default: begin
                    state <= sst_idle;
                end
            endcase
        end
    end

    ////////////////////////////////////////////////////////////
    // Outputs

    assign vector_load = (state == sst_restore_xfer) && xfer_done;
    assign restart = (state == sst_hold_reset) || (state == sst_wait_reset);   // Vector at 0

    assign cpu_pause = (state == sst_save_settle) || (state == sst_save_xfer)
                    || (state == sst_restore_xfer);
    assign cpu_reset = reset || (state == sst_restore_settle) || (state == sst_hold_reset);

    assign ss_state_out = state;

endmodule

`default_nettype wire

// ==== hdl/ss_settle_timer.sv ====
`timescale 1ns/100ps
`default_nettype none

`include "f2_sys_defines.svh"

module ss_settle_timer (
    input  wire  clk,
    input  wire  reset,
    input  wire  start,
    input  wire  long_hold,
    output logic done
);

    localparam int cnt_w = $clog2(`SS_HOLD_CYCLES + 1);
    localparam logic [cnt_w-1:0] settle_cnt = cnt_w'(`SS_SETTLE_CYCLES);
    localparam logic [cnt_w-1:0] hold_cnt = cnt_w'(`SS_HOLD_CYCLES);

    logic [cnt_w-1:0] count;
    logic [cnt_w-1:0] target;
    logic             running;
    logic             long_q;

    assign target = long_q ? hold_cnt : settle_cnt;
    assign done = running && (count == target);

    always_ff @(posedge clk) begin
        if (reset) begin
            running <= 1'b0;
            long_q  <= 1'b0;
            count   <= '0;
        end else if (start) begin
            running <= 1'b1;
            long_q  <= long_hold;
            count   <= cnt_w'(1);    // First clock after start
        end else if (running) begin
            if (done) begin
                running <= 1'b0;     // Hold until next start
            end else begin
                count <= count + 1'b1;
            end
        end
    end

endmodule

`default_nettype wire

// ==== hdl/f2_sys_pkg.sv ====
`default_nettype none

`include "f2_sys_defines.svh"

package f2_sys_pkg;

    typedef enum logic [3:0] {
        sst_idle,
        sst_start_save,
        sst_wait_save,
        sst_save_settle,
        sst_save_xfer,
        sst_restore_settle,
        sst_restore_xfer,
        sst_hold_reset,
        sst_wait_reset
    } ss_state_t;

    // Decoded CPU region
    typedef enum logic [3:0] {
        rgn_none,
        rgn_rom,
        rgn_work,
        rgn_screen,
        rgn_color,
        rgn_io,
        rgn_object,
        rgn_sound,
        rgn_ss_save,
        rgn_ss_reset,
        rgn_ss_vec
    } region_t;

    typedef struct packed {
        logic [`F2_ADDR_W-1:0] addr;   // Byte address of the word
        logic [1:0]            ds_n;   // Upper, lower
        logic                  rw;
        logic [`F2_DATA_W-1:0] wdata;
        logic [2:0]            fc;
    } cpu_bus_t;

    typedef struct packed {
        logic rom_n;
        logic work_n;
        logic screen_n;
        logic color_n;
        logic io_n;
        logic object_n;
        logic sound_n;
    } chip_sel_t;

    typedef struct packed {
        logic req;
        logic write;   // 1 for save
    } ss_xfer_t;

    typedef struct packed {
        logic vblank_n;
        logic dma_n;
        logic save;
    } irq_src_t;

endpackage

`default_nettype wire

// ==== hdl/f2_sys_defines.svh ====
`ifndef F2_SYS_DEFINES_SVH
`define F2_SYS_DEFINES_SVH

// CPU bus widths
`define F2_ADDR_W           24
`define F2_DATA_W           16
`define F2_SSP_W            32

// Save-state timing in clocks
`define SS_SETTLE_CYCLES    64
`define SS_HOLD_CYCLES      1000

// Handler stack pointer writes
`define SS_SSP_HI_ADDR      24'hff0000
`define SS_SSP_LO_ADDR      24'hff0002

`define SS_HANDLER_WORDS    13
`define SS_RESUME_HI        16'h00ff   // Restart entry in the handler
`define SS_RESUME_LO        16'h0008

`endif
